/* Makefile */
# Verilator flow for the memory map testbench, run from the project root
TOP := memoryMapTb
OBJ := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

# Builds and runs the testbench, the result comes from the log
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ) -f filelist.f
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* design/addrDecode.sv */
// Pure combinational region decode, gaps between windows give RegionNone
// Register index is zero outside the GTIA and ANTIC windows
`timescale 1ns/1ps

module addrDecode import memMapPkg::*; (
  input  addrT   paddr,
  output decodeT decode
);

  localparam addrT GtiaTop  = addrT'(GtiaBase + GtiaRegs - 1);
  localparam addrT AnticTop = addrT'(AnticBase + AnticRegs - 1);

  addrT gtiaOffset;
  addrT anticOffset;

  // Window offsets, only meaningful inside their window
  assign gtiaOffset  = paddr - GtiaBase;
  assign anticOffset = paddr - AnticBase;

  always_comb begin
    decode.region = RegionNone;
    decode.index  = '0;
    if (paddr <= RamTop) begin
      decode.region = RegionRam;
    end else if (paddr >= CartBase && paddr <= CartTop) begin
      decode.region = RegionCart;
    end else if (paddr >= GtiaBase && paddr <= GtiaTop) begin
      decode.region = RegionGtia;
      decode.index  = gtiaOffset[RegIndexWidth-1:0];
    end else if (paddr >= AnticBase && paddr <= AnticTop) begin
      decode.region = RegionAntic;
      decode.index  = anticOffset[RegIndexWidth-1:0];
    end else if (paddr >= BiosBase) begin
      decode.region = RegionBios; // Runs to the top of memory
    end
  end

endmodule

/* design/apbAccess.sv */
// APB slave phase logic with zero wait states
// Errors on unmapped addresses and on BIOS or cartridge writes
`timescale 1ns/1ps

module apbAccess import memMapPkg::*; (
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  decodeT decode,
  input  byteT   ramData,
  input  byteT   biosData,
  input  byteT   cartData,
  input  byteT   gtiaData,
  input  byteT   anticData,
  output logic   ramWe,
  output logic   gtiaWe,
  output logic   anticWe,
  output byteT   prdata,
  output logic   pready,
  output logic   pslverr
);

  logic access;   // Access phase strobe
  logic badAddr;  // Address in no window
  logic romWrite; // Write to a read-only region
  logic errFlag;
  logic wrStrobe;

  assign access   = psel && penable;
  assign badAddr  = decode.region == RegionNone;
  assign romWrite = pwrite && (decode.region == RegionBios || decode.region == RegionCart);
  assign errFlag  = badAddr || romWrite;

  assign pready   = access; // No wait states
  assign pslverr  = access && errFlag;

  // Writes commit on the edge that closes the access phase
  assign wrStrobe = access && pwrite;
  assign ramWe    = wrStrobe && decode.region == RegionRam;
  assign gtiaWe   = wrStrobe && decode.region == RegionGtia;
  assign anticWe  = wrStrobe && decode.region == RegionAntic;

  always_comb begin
    prdata = '0;
    if (!errFlag) begin
      case (decode.region)
        RegionRam:   prdata = ramData;   // Registered last cycle
        RegionBios:  prdata = biosData;  // Registered last cycle
        RegionCart:  prdata = cartData;
        RegionGtia:  prdata = gtiaData;
        RegionAntic: prdata = anticData;
        default:     prdata = '0;
      endcase
    end
  end

endmodule

/* design/bios.hex */
// One BIOS byte per line, offsets 0 to 15 from the BIOS base
A9
00
8D
00
C0
A2
FF
9A
D8
78
A9
40
8D
0E
D4
60

/* design/biosRom.sv */
// BIOS ROM loaded from hex at elaboration, bytes past the image read zero
`timescale 1ns/1ps

module biosRom import memMapPkg::*; (
  input  logic                     Fclk,
  input  logic [BiosAddrWidth-1:0] addr,
  output byteT                     rdata
);

  byteT rom [BiosDepth];

  initial begin
    for (int i = 0; i < BiosDepth; i++) begin
      rom[i] = '0; // Zero fill first
    end
    $readmemh(BiosFile, rom, 0, BiosInitWords - 1);
  end

  always_ff @(posedge Fclk) begin
    rdata <= rom[addr]; // One cycle read like the RAM
  end

endmodule

/* design/memMapPkg.sv */
// Shared map constants and types for the APB memory map
// Byte-wide data only, 16-bit processor address space
package memMapPkg;

  localparam int AddrWidth = 16;
  localparam int DataWidth = 8;

  localparam int RamDepth     = 16384;
  localparam int RamAddrWidth = 14;
  localparam int BiosDepth     = 2048;
  localparam int BiosAddrWidth = 11;
  localparam int CartAddrWidth = 15;

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] byteT;

  // Region boundaries, all inclusive
  localparam addrT RamTop    = 16'h3FFF;
  localparam addrT CartBase  = 16'h4000;
  localparam addrT CartTop   = 16'hBFFF;
  localparam addrT GtiaBase  = 16'hC000;
  localparam addrT AnticBase = 16'hD400;
  localparam addrT BiosBase  = 16'hF800;

  localparam int GtiaRegs      = 32;
  localparam int AnticRegs     = 16;
  localparam int RegIndexWidth = 5; // Sized for the GTIA bank

  // BIOS image, only the first words come from the file
  localparam string BiosFile      = "design/bios.hex";
  localparam int    BiosInitWords = 16;

  typedef enum logic [2:0] {
    RegionRam,
    RegionCart,
    RegionGtia,
    RegionAntic,
    RegionBios,
    RegionNone
  } regionT;

  typedef struct packed {
    regionT                   region;
    logic [RegIndexWidth-1:0] index; // Offset inside the GTIA or ANTIC window
  } decodeT;

  // One register write from the video chip side
  typedef struct packed {
    logic                     valid;
    logic [RegIndexWidth-1:0] index;
    byteT                     data;
  } chipWriteT;

endpackage

/* design/memoryMap.sv */
// Processor-side memory map top, APB slave with fixed two-cycle transfers
// Cartridge data returns combinationally from outside
`timescale 1ns/1ps

module memoryMap import memMapPkg::*; (
  input  logic                     Fclk,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  addrT                     paddr,
  input  byteT                     pwdata,
  output byteT                     prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [CartAddrWidth-1:0] cartAddr,
  input  byteT                     cartData,
  input  chipWriteT                gtiaChipWr,
  input  chipWriteT                anticChipWr,
  output byteT [GtiaRegs-1:0]      gtiaRegs,
  output byteT [AnticRegs-1:0]     anticRegs
);

  decodeT decode;
  byteT   ramData, biosData, gtiaData, anticData;
  logic   ramWe, gtiaWe, anticWe;
  addrT   cartOffset;

  assign cartOffset = paddr - CartBase;
  assign cartAddr   = cartOffset[CartAddrWidth-1:0]; // Offset into the 32 KB window

  addrDecode decoder (.paddr(paddr), .decode(decode));

  // Memories read from paddr every cycle
  workRam ram (
    .Fclk(Fclk), .we(ramWe), .addr(paddr[RamAddrWidth-1:0]),
    .wdata(pwdata), .rdata(ramData)
  );

  biosRom bios (.Fclk(Fclk), .addr(paddr[BiosAddrWidth-1:0]), .rdata(biosData));

  regBank #(.NumRegs(GtiaRegs)) gtiaBank (
    .Fclk(Fclk), .rst(rst), .cpuWe(gtiaWe), .cpuIndex(decode.index),
    .cpuData(pwdata), .chipWr(gtiaChipWr), .rdIndex(decode.index),
    .rdData(gtiaData), .regs(gtiaRegs)
  );

  regBank #(.NumRegs(AnticRegs)) anticBank (
    .Fclk(Fclk), .rst(rst), .cpuWe(anticWe), .cpuIndex(decode.index),
    .cpuData(pwdata), .chipWr(anticChipWr), .rdIndex(decode.index),
    .rdData(anticData), .regs(anticRegs)
  );

  apbAccess apb (
    .psel(psel), .penable(penable), .pwrite(pwrite), .decode(decode),
    .ramData(ramData), .biosData(biosData), .cartData(cartData),
    .gtiaData(gtiaData), .anticData(anticData),
    .ramWe(ramWe), .gtiaWe(gtiaWe), .anticWe(anticWe),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

endmodule

/* design/regBank.sv */
// Byte register bank with a processor port and a chip writeback port
// Same index in the same cycle keeps the processor byte
`timescale 1ns/1ps

module regBank import memMapPkg::*; #(
  parameter int NumRegs = 32
) (
  input  logic                     Fclk,
  input  logic                     rst,
  input  logic                     cpuWe,
  input  logic [RegIndexWidth-1:0] cpuIndex,
  input  byteT                     cpuData,
  input  chipWriteT                chipWr,
  input  logic [RegIndexWidth-1:0] rdIndex,
  output byteT                     rdData,
  output byteT [NumRegs-1:0]       regs
);

  localparam int IdxW = $clog2(NumRegs);

  logic cpuHit;  // Processor write lands in this bank
  logic chipHit; // Chip write lands and is not overridden

  assign cpuHit  = cpuWe && (cpuIndex < NumRegs);
  assign chipHit = chipWr.valid && (chipWr.index < NumRegs)
                   && !(cpuWe && cpuIndex == chipWr.index);

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else begin
      if (chipHit) begin
        regs[chipWr.index[IdxW-1:0]] <= chipWr.data;
      end
      if (cpuHit) begin
        regs[cpuIndex[IdxW-1:0]] <= cpuData; // Processor always applies
      end
    end
  end

  // Combinational readback, out of range reads zero
  always_comb begin
    rdData = '0;
    if (rdIndex < NumRegs) begin
      rdData = regs[rdIndex[IdxW-1:0]];
    end
  end

endmodule

/* design/workRam.sv */
// Work RAM, registered read with one cycle latency, contents not cleared
// Read during write returns the old byte
`timescale 1ns/1ps

module workRam import memMapPkg::*; (
  input  logic                    Fclk,
  input  logic                    we,
  input  logic [RamAddrWidth-1:0] addr,
  input  byteT                    wdata,
  output byteT                    rdata
);

  byteT mem [RamDepth]; // Maps to block RAM

  always_ff @(posedge Fclk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr]; // Setup phase address, data lands in access phase
  end

endmodule

/* filelist.f */
design/memMapPkg.sv
design/addrDecode.sv
design/workRam.sv
design/biosRom.sv
design/regBank.sv
design/apbAccess.sv
design/memoryMap.sv
verification/memoryMap_properties.sv
verification/memoryMapTb.sv

/* verification/memoryMapTb.sv */
// Directed testbench for memoryMap, acts as APB master with no wait states
// Reads design/bios.hex itself, so run from the project root
`timescale 1ns/1ps

module memoryMapTb import memMapPkg::*; ();

  localparam int ClkPeriod    = 20;
  localparam int NumTransfers = 210; // 48 + 80 + 30 + 22 + 24 + 5, rounded up
  localparam int WatchdogCycles = NumTransfers * 3 + 300; // Setup, access, idle each

  logic                     Fclk;
  logic                     rst;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  addrT                     paddr;
  byteT                     pwdata;
  byteT                     prdata;
  logic                     pready;
  logic                     pslverr;
  logic [CartAddrWidth-1:0] cartAddr;
  byteT                     cartData;
  chipWriteT                gtiaChipWr;
  chipWriteT                anticChipWr;
  byteT [GtiaRegs-1:0]      gtiaRegs;
  byteT [AnticRegs-1:0]     anticRegs;

  byteT                 biosImage [BiosInitWords];
  byteT [GtiaRegs-1:0]  gtiaModel;  // Expected GTIA bank
  byteT [AnticRegs-1:0] anticModel; // Expected ANTIC bank
  int errorCount;
  int checkCount;
  int testCount;
  int failedTests;

  assign cartData = paddr[7:0] ^ paddr[15:8]; // Cartridge model, low byte XOR high byte

  memoryMap memoryMap_inst (.*);

  initial begin
    Fclk = 1'b0;
    forever #(ClkPeriod / 2) Fclk = ~Fclk;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge Fclk);
    $display("Watchdog expired after %0d cycles, run did not finish", WatchdogCycles);
    $display("Regression failed");
    $finish;
  end

  task automatic compareByte(input string name, input byteT got, input byteT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic compareErr(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: pslverr (%s) got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compareCartAddr(input logic [CartAddrWidth-1:0] got,
                                 input logic [CartAddrWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t: cartAddr got %04h expected %04h", $time, got, exp);
    end
  endtask

  task automatic gtiaRegsMatch(input byteT [GtiaRegs-1:0] got, input byteT [GtiaRegs-1:0] exp);
    for (int i = 0; i < GtiaRegs; i++) begin
      compareByte($sformatf("gtiaRegs[%0d]", i), got[i], exp[i]);
    end
  endtask

  task automatic anticRegsMatch(input byteT [AnticRegs-1:0] got,
                                input byteT [AnticRegs-1:0] exp);
    for (int i = 0; i < AnticRegs; i++) begin
      compareByte($sformatf("anticRegs[%0d]", i), got[i], exp[i]);
    end
  endtask

  // One APB transfer, setup then access, returns what the slave gave back
  task automatic busTransfer(input logic write, input addrT addr, input byteT wdata,
                             output byteT rdata, output logic err);
    @(posedge Fclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge Fclk);
    penable <= 1'b1;
    @(negedge Fclk); // Outputs settled mid cycle
    if (!pready) begin
      errorCount++;
      $display("Error at %0t: pready low in the access phase for address %04h",
               $time, addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge Fclk); // Write commits on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input addrT addr, input byteT data, output logic err);
    byteT ignored;
    busTransfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apbRead(input addrT addr, output byteT data, output logic err);
    busTransfer(1'b0, addr, 8'h00, data, err);
  endtask

  function automatic chipWriteT makeChipWrite(input int idx, input byteT data);
    chipWriteT cw;
    cw.valid = 1'b1;
    cw.index = idx[RegIndexWidth-1:0];
    cw.data  = data;
    return cw;
  endfunction

  // Raises a chip write for the access cycle of a transfer started at the same time
  task automatic chipWriteInAccess(input logic toAntic, input int idx, input byteT data);
    repeat (2) @(posedge Fclk); // Setup edge, then access edge
    if (toAntic) begin
      anticChipWr <= makeChipWrite(idx, data);
    end else begin
      gtiaChipWr <= makeChipWrite(idx, data);
    end
    @(posedge Fclk);
    gtiaChipWr  <= '0;
    anticChipWr <= '0;
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("%s: pass", name);
    end else begin
      failedTests++;
      $display("%s: FAIL with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  task automatic resetValues();
    int   errorsBefore;
    byteT got;
    logic err;
    errorsBefore = errorCount;
    @(negedge Fclk);
    gtiaRegsMatch(gtiaRegs, gtiaModel); // Models are still all zero
    anticRegsMatch(anticRegs, anticModel);
    for (int i = 0; i < GtiaRegs; i++) begin
      apbRead(GtiaBase + addrT'(i), got, err);
      compareByte("prdata GTIA after reset", got, 8'h00);
      compareErr("GTIA read", err, 1'b0);
    end
    for (int i = 0; i < AnticRegs; i++) begin
      apbRead(AnticBase + addrT'(i), got, err);
      compareByte("prdata ANTIC after reset", got, 8'h00);
      compareErr("ANTIC read", err, 1'b0);
    end
    finishTest("reset values", errorsBefore);
  endtask

  task automatic ramReadback();
    int   errorsBefore;
    addrT addrList[$];
    byteT ramModel[addrT]; // Last byte written per address
    addrT addr;
    byteT data;
    logic err;
    errorsBefore = errorCount;
    for (int i = 0; i < 40; i++) begin
      addr = addrT'($urandom_range(RamTop));
      data = byteT'($urandom);
      apbWrite(addr, data, err);
      compareErr("RAM write", err, 1'b0);
      ramModel[addr] = data;
      addrList.push_back(addr);
    end
    foreach (addrList[i]) begin
      apbRead(addrList[i], data, err);
      compareByte("prdata RAM", data, ramModel[addrList[i]]);
      compareErr("RAM read", err, 1'b0);
    end
    finishTest("RAM readback", errorsBefore);
  endtask

  task automatic biosContents();
    int   errorsBefore;
    int   offset;
    byteT got;
    byteT exp;
    logic err;
    errorsBefore = errorCount;
    for (int i = 0; i < 28; i++) begin
      offset = (i < 24) ? i : 16 + int'($urandom_range(BiosDepth - 17)); // Tail is zero
      exp = (offset < BiosInitWords) ? biosImage[offset] : 8'h00;
      apbRead(BiosBase + addrT'(offset), got, err);
      compareByte($sformatf("prdata BIOS+%0d", offset), got, exp);
      compareErr("BIOS read", err, 1'b0);
    end
    apbWrite(BiosBase + 16'd2, ~biosImage[2], err);
    compareErr("BIOS write", err, 1'b1);
    apbRead(BiosBase + 16'd2, got, err);
    compareByte("prdata BIOS after write", got, biosImage[2]); // ROM keeps its byte
    finishTest("BIOS contents", errorsBefore);
  endtask

  task automatic cartAndUnmapped();
    int   errorsBefore;
    addrT unmapped[6] = '{16'hC020, 16'hC3FF, 16'hD3FF, 16'hD410, 16'hE000, 16'hF7FF};
    addrT addr;
    addrT offset;
    byteT got;
    logic err;
    errorsBefore = errorCount;
    for (int i = 0; i < 14; i++) begin
      case (i)
        0:       addr = CartBase;
        1:       addr = CartTop;
        default: addr = CartBase + addrT'($urandom_range(CartTop - CartBase));
      endcase
      apbRead(addr, got, err);
      offset = addr - CartBase;
      compareCartAddr(cartAddr, offset[CartAddrWidth-1:0]); // paddr still held
      compareByte("prdata cartridge", got, addr[7:0] ^ addr[15:8]);
      compareErr("cartridge read", err, 1'b0);
    end
    apbWrite(CartBase + 16'h0123, 8'h5A, err);
    compareErr("cartridge write", err, 1'b1);
    foreach (unmapped[i]) begin
      apbRead(unmapped[i], got, err);
      compareByte("prdata unmapped", got, 8'h00);
      compareErr("unmapped read", err, 1'b1);
    end
    apbWrite(16'hE000, 8'hC3, err);
    compareErr("unmapped write", err, 1'b1);
    finishTest("cartridge and unmapped", errorsBefore);
  endtask

  task automatic cpuRegisterWrites();
    int   errorsBefore;
    int   idx;
    byteT data;
    byteT got;
    logic err;
    errorsBefore = errorCount;
    for (int i = 0; i < 6; i++) begin
      idx  = $urandom_range(GtiaRegs - 1);
      data = byteT'($urandom);
      apbWrite(GtiaBase + addrT'(idx), data, err);
      compareErr("GTIA write", err, 1'b0);
      gtiaModel[idx] = data;
      @(negedge Fclk);
      gtiaRegsMatch(gtiaRegs, gtiaModel);
      apbRead(GtiaBase + addrT'(idx), got, err);
      compareByte("prdata GTIA", got, data);
      idx  = $urandom_range(AnticRegs - 1);
      data = byteT'($urandom);
      apbWrite(AnticBase + addrT'(idx), data, err);
      compareErr("ANTIC write", err, 1'b0);
      anticModel[idx] = data;
      @(negedge Fclk);
      anticRegsMatch(anticRegs, anticModel);
      apbRead(AnticBase + addrT'(idx), got, err);
      compareByte("prdata ANTIC", got, data);
    end
    finishTest("processor register writes", errorsBefore);
  endtask

  task automatic chipWriteRules();
    int   errorsBefore;
    byteT got;
    logic err;
    errorsBefore = errorCount;
    @(posedge Fclk); // Chip writes on their own
    gtiaChipWr  <= makeChipWrite(7, 8'hA5);
    anticChipWr <= makeChipWrite(2, 8'h3C);
    @(posedge Fclk);
    gtiaChipWr  <= '0;
    anticChipWr <= '0;
    gtiaModel[7]  = 8'hA5;
    anticModel[2] = 8'h3C;
    @(negedge Fclk);
    gtiaRegsMatch(gtiaRegs, gtiaModel);
    anticRegsMatch(anticRegs, anticModel);
    fork // Same GTIA index, processor byte must stay
      apbWrite(GtiaBase + 16'd9, 8'h11, err);
      chipWriteInAccess(1'b0, 9, 8'hEE);
    join
    gtiaModel[9] = 8'h11;
    fork // Different GTIA indexes, both land
      apbWrite(GtiaBase + 16'd10, 8'h22, err);
      chipWriteInAccess(1'b0, 11, 8'h33);
    join
    gtiaModel[10] = 8'h22;
    gtiaModel[11] = 8'h33;
    fork
      apbWrite(AnticBase + 16'd4, 8'h44, err);
      chipWriteInAccess(1'b1, 4, 8'hBB);
    join
    anticModel[4] = 8'h44;
    @(negedge Fclk);
    gtiaRegsMatch(gtiaRegs, gtiaModel);
    anticRegsMatch(anticRegs, anticModel);
    apbRead(GtiaBase + 16'd9, got, err);
    compareByte("prdata GTIA after collision", got, 8'h11);
    apbRead(AnticBase + 16'd4, got, err);
    compareByte("prdata ANTIC after collision", got, 8'h44);
    finishTest("chip write rules", errorsBefore);
  endtask

  initial begin
    int seedValue;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    gtiaChipWr  = '0;
    anticChipWr = '0;
    gtiaModel   = '0;
    anticModel  = '0;
    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    failedTests = 0;
    seedValue   = $urandom(10); // Seed once for the whole run
    $readmemh(BiosFile, biosImage);
    repeat (5) @(posedge Fclk);
    rst <= 1'b0;
    resetValues();
    ramReadback();
    biosContents();
    cartAndUnmapped();
    cpuRegisterWrites();
    chipWriteRules();
    @(posedge Fclk);
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verification/memoryMap_properties.sv */
// APB protocol checks for memoryMap, attached to every instance with bind
// All checks are idle while rst is high
`timescale 1ns/1ps

module memoryMapProperties import memMapPkg::*; (
  input logic Fclk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic ramWe,
  input logic gtiaWe,
  input logic anticWe,
  input byteT prdata
);

  logic accessPhase;
  logic anyWrite; // Any target write enable

  assign accessPhase = psel && penable;
  assign anyWrite    = ramWe || gtiaWe || anticWe;

  readyInAccess: assert property (@(posedge Fclk) disable iff (rst)
    pready |-> accessPhase) else $error("pready outside an access phase");

  errWithReady: assert property (@(posedge Fclk) disable iff (rst)
    pslverr |-> pready) else $error("pslverr without pready");

  // Read data must be clean whenever the slave completes
  rdataKnown: assert property (@(posedge Fclk) disable iff (rst)
    pready |-> !$isunknown(prdata)) else $error("unknown prdata while pready is high");

  writeInAccess: assert property (@(posedge Fclk) disable iff (rst)
    anyWrite |-> accessPhase) else $error("write enable outside an access phase");

endmodule

bind memoryMap memoryMapProperties props (
  .Fclk(Fclk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
  .pslverr(pslverr), .ramWe(ramWe), .gtiaWe(gtiaWe), .anticWe(anticWe), .prdata(prdata)
);
